// ==== Bender.yml ====
package:
  name: rooth

sources:
  - rooth_pkg.sv
  - inst_decode.sv
  - regs_file.sv
  - alu_exec.sv
  - rooth.sv
  - target: simulation
    files:
      - rooth_sva.sv
      - tb_rooth.sv

// ==== alu_exec.sv ====
// operand select, alu and retire register
`default_nettype none

module alu_exec (
    input  wire logic                            clk,
    input  wire logic                            rst_n_i,
    input  rooth_pkg::decoded_op_t               dec_op_i,
    input  wire logic [rooth_pkg::CPU_WIDTH-1:0] rs1_data_i,
    input  wire logic [rooth_pkg::CPU_WIDTH-1:0] rs2_data_i,
    output rooth_pkg::retire_t                   retire_o
);

    logic [rooth_pkg::CPU_WIDTH-1:0]      op_a;
    logic [rooth_pkg::CPU_WIDTH-1:0]      op_b;
    logic [rooth_pkg::SHAMT_WIDTH-1:0]    shamt;
    logic                                 lt_s;
    logic                                 lt_u;
    logic [rooth_pkg::CPU_WIDTH-1:0]      alu_res;
    logic                                 retire_vld_q;
    logic [rooth_pkg::REG_ADDR_WIDTH-1:0] retire_rd_q;
    logic [rooth_pkg::CPU_WIDTH-1:0]      retire_data_q;

    // ----------------------------------------
    // operands
    // ----------------------------------------
    assign op_a  = rs1_data_i;
    assign op_b  = dec_op_i.use_imm ? dec_op_i.imm : rs2_data_i;
    assign shamt = op_b[rooth_pkg::SHAMT_WIDTH-1:0];

    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    // ----------------------------------------
    // alu
    // ----------------------------------------
    always_comb begin
        case (dec_op_i.alu_op)
            rooth_pkg::ALU_ADD:  alu_res = op_a + op_b;
            rooth_pkg::ALU_SUB:  alu_res = op_a - op_b;
            rooth_pkg::ALU_SLL:  alu_res = op_a << shamt;
            rooth_pkg::ALU_SLT:  alu_res = {{(rooth_pkg::CPU_WIDTH-1){1'b0}}, lt_s};
            rooth_pkg::ALU_SLTU: alu_res = {{(rooth_pkg::CPU_WIDTH-1){1'b0}}, lt_u};
            rooth_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            rooth_pkg::ALU_SRL:  alu_res = op_a >> shamt;
            rooth_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
            rooth_pkg::ALU_OR:   alu_res = op_a | op_b;
            rooth_pkg::ALU_AND:  alu_res = op_a & op_b;
            // lui, immediate already shifted up
            rooth_pkg::ALU_LUI:  alu_res = op_b;
            default:             alu_res = '0;
        endcase
    end

    // ----------------------------------------
    // retire register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_vld_q <= 1'b0;
        end else begin
            retire_vld_q <= dec_op_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_op_i.valid) begin
            retire_rd_q   <= dec_op_i.rd;
            retire_data_q <= alu_res;
        end
    end

    assign retire_o = '{valid: retire_vld_q, rd: retire_rd_q, data: retire_data_q};

endmodule

`default_nettype wire

// ==== inst_decode.sv ====
// program counter, fetch register, decode and immediate generation
`default_nettype none

module inst_decode (
    input  wire logic                              clk,
    input  wire logic                              rst_n_i,
    input  wire logic [rooth_pkg::CPU_WIDTH-1:0]   pc_inst_i,
    output logic      [rooth_pkg::CPU_WIDTH-1:0]   pc_curr_pc_o,
    output rooth_pkg::reg_rd_t                     reg_rd_o,
    output rooth_pkg::decoded_op_t                 dec_op_o
);

    logic [rooth_pkg::CPU_WIDTH-1:0] pc_q;
    rooth_pkg::inst_u                fetch_q;
    logic                            fetch_vld_q;
    rooth_pkg::decoded_op_t          dec_d;
    logic                            op_ok;
    logic                            alt_f7;

    // ----------------------------------------
    // pc and fetch register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q        <= '0;
            fetch_vld_q <= 1'b0;
        end else begin
            pc_q        <= pc_q + rooth_pkg::PC_STEP;
            fetch_vld_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        fetch_q <= pc_inst_i;
    end

    // ----------------------------------------
    // decode
    // ----------------------------------------
    assign alt_f7 = (fetch_q.r_fmt.funct7 == rooth_pkg::FUNCT7_ALT);

    always_comb begin
        op_ok         = 1'b0;
        dec_d.alu_op  = rooth_pkg::ALU_ADD;
        dec_d.rd      = fetch_q.i_fmt.rd;
        dec_d.rs1     = '0;
        dec_d.rs2     = '0;
        dec_d.use_imm = 1'b0;
        dec_d.imm     = '0;
        case (fetch_q.r_fmt.opcode)
            rooth_pkg::OPCODE_OP: begin
                dec_d.rs1 = fetch_q.r_fmt.rs1;
                dec_d.rs2 = fetch_q.r_fmt.rs2;
                // alt funct7 only exists for sub and sra
                op_ok = (fetch_q.r_fmt.funct7 == rooth_pkg::FUNCT7_BASE) ||
                        (alt_f7 && (fetch_q.r_fmt.funct3 == 3'b000 ||
                                    fetch_q.r_fmt.funct3 == 3'b101));
                case (fetch_q.r_fmt.funct3)
                    3'b000:  dec_d.alu_op = alt_f7 ? rooth_pkg::ALU_SUB : rooth_pkg::ALU_ADD;
                    3'b001:  dec_d.alu_op = rooth_pkg::ALU_SLL;
                    3'b010:  dec_d.alu_op = rooth_pkg::ALU_SLT;
                    3'b011:  dec_d.alu_op = rooth_pkg::ALU_SLTU;
                    3'b100:  dec_d.alu_op = rooth_pkg::ALU_XOR;
                    3'b101:  dec_d.alu_op = alt_f7 ? rooth_pkg::ALU_SRA : rooth_pkg::ALU_SRL;
                    3'b110:  dec_d.alu_op = rooth_pkg::ALU_OR;
                    default: dec_d.alu_op = rooth_pkg::ALU_AND;
                endcase
            end
            rooth_pkg::OPCODE_OP_IMM: begin
                dec_d.rs1     = fetch_q.i_fmt.rs1;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = {{(rooth_pkg::CPU_WIDTH-12){fetch_q.i_fmt.imm12[11]}},
                                 fetch_q.i_fmt.imm12};
                op_ok         = 1'b1;
                case (fetch_q.i_fmt.funct3)
                    3'b000:  dec_d.alu_op = rooth_pkg::ALU_ADD;
                    3'b010:  dec_d.alu_op = rooth_pkg::ALU_SLT;
                    3'b011:  dec_d.alu_op = rooth_pkg::ALU_SLTU;
                    3'b100:  dec_d.alu_op = rooth_pkg::ALU_XOR;
                    3'b110:  dec_d.alu_op = rooth_pkg::ALU_OR;
                    3'b111:  dec_d.alu_op = rooth_pkg::ALU_AND;
                    3'b001: begin
                        dec_d.alu_op = rooth_pkg::ALU_SLL;
                        op_ok = (fetch_q.i_fmt.imm12[11:5] == rooth_pkg::FUNCT7_BASE);
                    end
                    default: begin
                        // bit 30 picks srai over srli
                        dec_d.alu_op = fetch_q.i_fmt.imm12[10] ? rooth_pkg::ALU_SRA
                                                               : rooth_pkg::ALU_SRL;
                        op_ok = (fetch_q.i_fmt.imm12[11:5] == rooth_pkg::FUNCT7_BASE) ||
                                (fetch_q.i_fmt.imm12[11:5] == rooth_pkg::FUNCT7_ALT);
                    end
                endcase
                // shift forms carry the shift amount only
                if (fetch_q.i_fmt.funct3 == 3'b001 || fetch_q.i_fmt.funct3 == 3'b101) begin
                    dec_d.imm = {{(rooth_pkg::CPU_WIDTH-rooth_pkg::SHAMT_WIDTH){1'b0}},
                                 fetch_q.i_fmt.imm12[rooth_pkg::SHAMT_WIDTH-1:0]};
                end
            end
            rooth_pkg::OPCODE_LUI: begin
                dec_d.alu_op  = rooth_pkg::ALU_LUI;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = {fetch_q.i_fmt.imm12, fetch_q.i_fmt.rs1,
                                 fetch_q.i_fmt.funct3, 12'b0};
                op_ok         = 1'b1;
            end
            default: begin
                op_ok = 1'b0;
            end
        endcase
        // x0 writes retire nothing
        dec_d.valid = fetch_vld_q && op_ok && (dec_d.rd != '0);
    end

    assign pc_curr_pc_o = pc_q;
    assign reg_rd_o     = '{rs1: dec_d.rs1, rs2: dec_d.rs2};
    assign dec_op_o     = dec_d;

endmodule

`default_nettype wire

// ==== regs_file.sv ====
// general register file with write-back bypass and debug read port
`default_nettype none

module regs_file (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n_i,
    input  rooth_pkg::reg_rd_t                        reg_rd_i,
    input  rooth_pkg::retire_t                        retire_i,
    output logic      [rooth_pkg::CPU_WIDTH-1:0]      rs1_data_o,
    output logic      [rooth_pkg::CPU_WIDTH-1:0]      rs2_data_o,
    input  wire logic [rooth_pkg::REG_ADDR_WIDTH-1:0] jtag_addr_i,
    output logic      [rooth_pkg::CPU_WIDTH-1:0]      jtag_data_o
);

    logic [rooth_pkg::CPU_WIDTH-1:0] regs_q [rooth_pkg::REG_NUM];

    // operand read, pending write wins on a match
    function automatic logic [rooth_pkg::CPU_WIDTH-1:0] read_port(
        input logic [rooth_pkg::REG_ADDR_WIDTH-1:0] idx,
        input logic [rooth_pkg::CPU_WIDTH-1:0]      stored,
        input rooth_pkg::retire_t                   wb
    );
        if (idx == '0) begin
            return '0;
        end else if (wb.valid && wb.rd == idx) begin
            return wb.data;
        end
        return stored;
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < rooth_pkg::REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (retire_i.valid && retire_i.rd != '0) begin
            regs_q[retire_i.rd] <= retire_i.data;
        end
    end

    assign rs1_data_o = read_port(reg_rd_i.rs1, regs_q[reg_rd_i.rs1], retire_i);
    assign rs2_data_o = read_port(reg_rd_i.rs2, regs_q[reg_rd_i.rs2], retire_i);

    // debug view of the array only
    assign jtag_data_o = regs_q[jtag_addr_i];

endmodule

`default_nettype wire

// ==== rooth.sv ====
// core top: fetch and decode, register file, execute and retire
`default_nettype none

module rooth (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n_i,
    input  wire logic [rooth_pkg::CPU_WIDTH-1:0]      pc_inst_i,
    output logic      [rooth_pkg::CPU_WIDTH-1:0]      pc_curr_pc_o,
    output rooth_pkg::retire_t                        retire_o,
    input  wire logic [rooth_pkg::REG_ADDR_WIDTH-1:0] jtag_addr_i,
    output logic      [rooth_pkg::CPU_WIDTH-1:0]      jtag_data_o
);

    rooth_pkg::reg_rd_t              de_reg_rd;
    rooth_pkg::decoded_op_t          de_dec_op;
    logic [rooth_pkg::CPU_WIDTH-1:0] ex_rs1_data;
    logic [rooth_pkg::CPU_WIDTH-1:0] ex_rs2_data;

    inst_decode u_inst_decode_0 (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .pc_inst_i      ( pc_inst_i     ),
        .pc_curr_pc_o   ( pc_curr_pc_o  ),
        .reg_rd_o       ( de_reg_rd     ),
        .dec_op_o       ( de_dec_op     )
    );

    // retire record doubles as the write port
    regs_file u_regs_file_0 (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .reg_rd_i       ( de_reg_rd     ),
        .retire_i       ( retire_o      ),
        .rs1_data_o     ( ex_rs1_data   ),
        .rs2_data_o     ( ex_rs2_data   ),
        .jtag_addr_i    ( jtag_addr_i   ),
        .jtag_data_o    ( jtag_data_o   )
    );

    alu_exec u_alu_exec_0 (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .dec_op_i       ( de_dec_op     ),
        .rs1_data_i     ( ex_rs1_data   ),
        .rs2_data_i     ( ex_rs2_data   ),
        .retire_o       ( retire_o      )
    );

endmodule

`default_nettype wire

// ==== rooth_pkg.sv ====
// shared widths, opcodes, alu op codes, instruction union and stage records
`default_nettype none

package rooth_pkg;

    // ----------------------------------------
    // widths and constants
    // ----------------------------------------
    localparam int CPU_WIDTH      = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int REG_NUM        = 32;
    localparam int SHAMT_WIDTH    = $clog2(CPU_WIDTH);

    localparam logic [CPU_WIDTH-1:0] PC_STEP = 4;

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

    // funct7 of the base ops and of sub / sra
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI
    } alu_op_e;

    // ----------------------------------------
    // instruction word, two layouts
    // ----------------------------------------
    typedef struct packed {
        logic [6:0]                funct7;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                funct3;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]               imm12;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                funct3;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } inst_u;

    // ----------------------------------------
    // stage records
    // ----------------------------------------
    typedef struct packed {
        logic                      valid;
        alu_op_e                   alu_op;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        logic                      use_imm;
        logic [CPU_WIDTH-1:0]      imm;
    } decoded_op_t;

    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
    } reg_rd_t;

    // write-back record, also the bypass source
    typedef struct packed {
        logic                      valid;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [CPU_WIDTH-1:0]      data;
    } retire_t;

endpackage

`default_nettype wire

// ==== rooth_sva.sv ====
// concurrent assertions on the rooth top level and their bind
`default_nettype none

module rooth_sva (
    input wire logic                            clk,
    input wire logic                            rst_n_i,
    input wire logic [rooth_pkg::CPU_WIDTH-1:0] pc_curr_pc_o,
    input rooth_pkg::retire_t                   retire_o
);

    int assert_fails = 0;

    // pipeline is empty in the first cycle out of reset
    assert property (@(posedge clk) $rose(rst_n_i) |=> !retire_o.valid)
        else begin
            $error("retire valid in the first cycle after reset");
            assert_fails++;
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
                     retire_o.valid |-> retire_o.rd != '0)
        else begin
            $error("retire to x0");
            assert_fails++;
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
                     $past(rst_n_i) |-> pc_curr_pc_o == $past(pc_curr_pc_o) + rooth_pkg::PC_STEP)
        else begin
            $error("pc did not advance by one step");
            assert_fails++;
        end

endmodule

bind rooth rooth_sva u_rooth_sva (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .pc_curr_pc_o ( pc_curr_pc_o ),
    .retire_o     ( retire_o     )
);

`default_nettype wire

// ==== src.f ====
rooth_pkg.sv
inst_decode.sv
regs_file.sv
alu_exec.sv
rooth.sv
rooth_sva.sv
tb_rooth.sv

// ==== tb_rooth.sv ====
// testbench with program loading, reference model, retire checker, watchdog and report
`default_nettype none

module tb_rooth;

    localparam int CLK_PERIOD = 8;
    localparam int MEM_DEPTH  = 256;
    localparam int RAND_LEN   = 200;
    localparam int N_TESTS    = 6;
    localparam int MAX_PROG   = RAND_LEN;
    localparam logic [31:0] SEED = 32'h6586957b;

    logic                       clk;
    logic                       rst_n_i;
    logic [31:0]                pc_inst_i;
    logic [31:0]                pc_curr_pc_o;
    rooth_pkg::retire_t         retire_o;
    logic [4:0]                 jtag_addr_i;
    logic [31:0]                jtag_data_o;

    logic [31:0]                prog [MEM_DEPTH];
    int                         prog_len;
    logic [31:0]                model_regs [rooth_pkg::REG_NUM];
    rooth_pkg::retire_t         expect_q [$];
    rooth_pkg::retire_t         exp_rec;
    int                         errors;
    int                         tests_run;
    int                         tests_failed;

    rooth DUT (
        .clk          ( clk          ),
        .rst_n_i      ( rst_n_i      ),
        .pc_inst_i    ( pc_inst_i    ),
        .pc_curr_pc_o ( pc_curr_pc_o ),
        .retire_o     ( retire_o     ),
        .jtag_addr_i  ( jtag_addr_i  ),
        .jtag_data_o  ( jtag_data_o  )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // asynchronous instruction memory that reads zero past the program
    function automatic logic [31:0] fetch_word(input logic [31:0] pc);
        if ((pc >> 2) < prog_len) begin
            return prog[pc >> 2];
        end
        return '0;
    endfunction

    initial begin
        pc_inst_i = '0;
        forever begin
            @(posedge clk);
            #1;
            pc_inst_i = fetch_word(pc_curr_pc_o);
        end
    end

    // ----------------------------------------
    // encoders and reference model
    // ----------------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rooth_pkg::OPCODE_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input int rd,
                                          input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], rooth_pkg::OPCODE_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_lui(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], rooth_pkg::OPCODE_LUI};
    endfunction

    function automatic rooth_pkg::retire_t ref_exec(input logic [31:0] w);
        rooth_pkg::retire_t r;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        d;
        logic [2:0]         f3;
        logic               alt;
        logic               ok;
        f3  = w[14:12];
        a   = model_regs[w[19:15]];
        b   = model_regs[w[24:20]];
        alt = 1'b0;
        ok  = 1'b1;
        d   = '0;
        case (w[6:0])
            7'h33: begin
                ok  = w[31:25] == 7'h00 || (w[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                alt = w[30];
            end
            7'h13: begin
                b = {{20{w[31]}}, w[31:20]};
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    b   = {27'd0, w[24:20]};
                    alt = (f3 == 3'd5) && w[30];
                    ok  = w[31:25] == 7'h00 || (f3 == 3'd5 && w[31:25] == 7'h20);
                end
            end
            7'h37: begin
                ok = 1'b1;
            end
            default: begin
                ok = 1'b0;
            end
        endcase
        case (f3)
            3'd0: d = alt ? a - b : a + b;
            3'd1: d = a << b[4:0];
            3'd2: d = {31'd0, $signed(a) < $signed(b)};
            3'd3: d = {31'd0, a < b};
            3'd4: d = a ^ b;
            3'd5: begin
                if (alt) begin
                    d = $signed(a) >>> b[4:0];
                end else begin
                    d = a >> b[4:0];
                end
            end
            3'd6: d = a | b;
            default: d = a & b;
        endcase
        if (w[6:0] == 7'h37) begin
            d = {w[31:12], 12'd0};
        end
        r.valid = ok && (w[11:7] != 5'd0);
        r.rd    = w[11:7];
        r.data  = d;
        return r;
    endfunction

    task automatic build_expect();
        rooth_pkg::retire_t r;
        for (int i = 0; i < rooth_pkg::REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < prog_len; i++) begin
            r = ref_exec(prog[i]);
            if (r.valid) begin
                model_regs[r.rd] = r.data;
                expect_q.push_back(r);
            end
        end
    endtask

    // ----------------------------------------
    // retire checker
    // ----------------------------------------
    always @(negedge clk) begin
        if (rst_n_i && retire_o.valid) begin
            if (expect_q.size() == 0) begin
                $display("unexpected retire to x%0d at time %0t with nothing pending",
                         retire_o.rd, $time);
                errors++;
            end else begin
                exp_rec = expect_q.pop_front();
                if (retire_o.rd !== exp_rec.rd || retire_o.data !== exp_rec.data) begin
                    $display("Error at %0t: retire x%0d = %h, expected x%0d = %h", $time,
                             retire_o.rd, retire_o.data, exp_rec.rd, exp_rec.data);
                    errors++;
                end
            end
        end
    end

    function automatic int total_errors();
        return errors + DUT.u_rooth_sva.assert_fails;
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic start_test();
        @(posedge clk);
        #1;
        rst_n_i  = 1'b0;
        prog_len = 0;
        expect_q.delete();
    endtask

    task automatic check_regs();
        for (int i = 0; i < rooth_pkg::REG_NUM; i++) begin
            @(posedge clk);
            #1;
            jtag_addr_i = i[4:0];
            @(negedge clk);
            if (jtag_data_o !== model_regs[i]) begin
                $display("Error at %0t: debug read of x%0d = %h, expected %h", $time, i,
                         jtag_data_o, model_regs[i]);
                errors++;
            end
        end
    endtask

    task automatic run_test(input string name);
        int errs_at_start;
        int cycles;
        errs_at_start = total_errors();
        build_expect();
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk);
        if (pc_curr_pc_o !== '0 || retire_o.valid !== 1'b0) begin
            $display("Error at %0t: pc %h, retire valid %b right after reset", $time,
                     pc_curr_pc_o, retire_o.valid);
            errors++;
        end
        cycles = 0;
        while ((pc_curr_pc_o < 4 * (prog_len + 2) || expect_q.size() != 0) &&
               cycles < prog_len + 12) begin
            @(negedge clk);
            cycles++;
        end
        // trailing cycles catch late spurious retires
        repeat (2) @(negedge clk);
        if (expect_q.size() != 0) begin
            $display("%0d expected results of test %s never retired", expect_q.size(), name);
            errors += expect_q.size();
            expect_q.delete();
        end
        check_regs();
        tests_run++;
        if (total_errors() == errs_at_start) begin
            $display("test %-8s ok", name);
        end else begin
            tests_failed++;
            $display("test %-8s FAILED", name);
        end
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic test_reg_ops();
        start_test();
        emit(enc_lui(1, 32'h80000));
        emit(enc_i(3'd0, 2, 0, -1));
        emit(enc_i(3'd0, 3, 0, 1));
        emit(enc_i(3'd0, 4, 0, 5));
        emit(enc_i(3'd0, 5, 1, -1));
        emit(enc_r(7'h00, 3'd0, 6, 1, 2));
        emit(enc_r(7'h20, 3'd0, 7, 3, 4));
        emit(enc_r(7'h00, 3'd1, 8, 3, 4));
        emit(enc_r(7'h00, 3'd2, 9, 1, 3));
        emit(enc_r(7'h00, 3'd2, 10, 3, 1));
        emit(enc_r(7'h00, 3'd3, 11, 3, 2));
        emit(enc_r(7'h00, 3'd3, 12, 2, 3));
        emit(enc_r(7'h00, 3'd2, 13, 5, 1));
        emit(enc_r(7'h00, 3'd4, 14, 1, 2));
        emit(enc_r(7'h00, 3'd5, 15, 1, 4));
        emit(enc_r(7'h20, 3'd5, 16, 1, 4));
        emit(enc_r(7'h00, 3'd6, 17, 3, 4));
        emit(enc_r(7'h00, 3'd7, 18, 2, 4));
        run_test("reg_ops");
    endtask

    task automatic test_imm_ops();
        start_test();
        emit(enc_i(3'd0, 1, 0, -2048));
        emit(enc_i(3'd0, 2, 0, 2047));
        emit(enc_lui(3, 32'hF0000));
        emit(enc_i(3'd2, 4, 1, -1));
        emit(enc_i(3'd2, 5, 2, -1));
        emit(enc_i(3'd3, 6, 1, -1));
        emit(enc_i(3'd3, 7, 2, 1));
        emit(enc_i(3'd4, 8, 1, -1));
        emit(enc_i(3'd6, 9, 2, -256));
        emit(enc_i(3'd7, 10, 1, -16));
        emit(enc_i(3'd1, 11, 2, 4));
        emit(enc_i(3'd5, 12, 3, 8));
        emit(enc_i(3'd5, 13, 3, 32'h400 + 8));
        emit(enc_i(3'd5, 14, 1, 32'h400 + 31));
        emit(enc_i(3'd5, 15, 1, 31));
        emit(enc_i(3'd0, 16, 3, -1));
        run_test("imm_ops");
    endtask

    task automatic test_chains();
        start_test();
        emit(enc_i(3'd0, 1, 0, 3));
        for (int i = 2; i < 6; i++) begin
            emit(enc_r(7'h00, 3'd0, i, i - 1, i - 1));
        end
        emit(enc_r(7'h20, 3'd0, 6, 5, 1));
        emit(enc_i(3'd1, 7, 6, 3));
        emit(enc_i(3'd5, 8, 7, 32'h400 + 2));
        emit(enc_i(3'd4, 9, 8, -1));
        emit(enc_r(7'h00, 3'd3, 10, 9, 8));
        emit(enc_i(3'd0, 11, 0, -7));
        for (int i = 0; i < 4; i++) begin
            emit(enc_r(7'h00, 3'd0, 11, 11, 9));
        end
        run_test("chains");
    endtask

    task automatic test_x0();
        start_test();
        emit(enc_i(3'd0, 1, 0, 9));
        emit(enc_i(3'd0, 0, 0, 5));
        emit(enc_r(7'h00, 3'd0, 0, 1, 1));
        emit(enc_lui(0, 32'hABCDE));
        emit(32'h0000_0063);
        emit(32'h0000_2003);
        emit(enc_r(7'h01, 3'd0, 3, 1, 1));
        emit(enc_i(3'd1, 4, 1, 32'h400 + 3));
        emit(enc_r(7'h20, 3'd4, 5, 1, 1));
        emit(enc_r(7'h00, 3'd0, 6, 0, 0));
        emit(enc_i(3'd0, 7, 0, 0));
        emit(enc_r(7'h20, 3'd0, 8, 1, 0));
        run_test("x0");
    endtask

    task automatic test_random();
        int k;
        int rd;
        int rs1;
        int rs2;
        int imm;
        start_test();
        for (int n = 0; n < RAND_LEN; n++) begin
            k   = $urandom_range(0, 18);
            rd  = $urandom_range(0, 7);
            rs1 = $urandom_range(0, 7);
            rs2 = $urandom_range(0, 7);
            imm = $urandom_range(0, 4095);
            if (k < 8) begin
                emit(enc_r(7'h00, k[2:0], rd, rs1, rs2));
            end else if (k < 10) begin
                emit(enc_r(7'h20, (k == 8) ? 3'd0 : 3'd5, rd, rs1, rs2));
            end else if (k < 18) begin
                // shift forms keep only shamt and the srai bit
                if (k == 11) begin
                    imm = imm & 32'h01f;
                end else if (k == 15) begin
                    imm = imm & 32'h41f;
                end
                emit(enc_i(3'(k - 10), rd, rs1, imm));
            end else begin
                emit(enc_lui(rd, $urandom));
            end
        end
        run_test("random");
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n_i      = 1'b0;
        jtag_addr_i  = '0;
        prog_len     = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        start_test();
        run_test("reset");
        test_reg_ops();
        test_imm_ops();
        test_chains();
        test_x0();
        test_random();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(N_TESTS * (MAX_PROG + 20) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
